//--- obi_pkg.sv
// ------------------------------
// obi bus package
// widths and field types of the request/response bus
// ------------------------------
package obi_pkg;

  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [BE_WIDTH-1:0]   be_t;

endpackage

//--- mcu_pkg.sv
// ------------------------------
// microcontroller package
// memory map, register offsets and sizing defaults
// ------------------------------
package mcu_pkg;

  // sizing defaults, overridable from the top level
  localparam int unsigned NUM_BANKS  = 2;
  localparam int unsigned BANK_WORDS = 1024;
  localparam int unsigned GPIO_WIDTH = 32;

  // memory map
  localparam obi_pkg::addr_t RAM_START      = 32'h0000_0000;
  localparam obi_pkg::addr_t SOC_CTRL_START = 32'h2000_0000;
  localparam obi_pkg::addr_t GPIO_START     = 32'h3000_0000;
  localparam obi_pkg::addr_t PERIPH_SIZE    = 32'h0000_0100;

  // low address bits that select a register inside a peripheral window
  localparam int unsigned OFFSET_WIDTH = $clog2(PERIPH_SIZE);

  // control block
  localparam logic [OFFSET_WIDTH-1:0] EXIT_VALID_OFFSET = 8'h00;
  localparam logic [OFFSET_WIDTH-1:0] EXIT_VALUE_OFFSET = 8'h04;
  localparam logic [OFFSET_WIDTH-1:0] SCRATCH_OFFSET    = 8'h08;

  // gpio
  localparam logic [OFFSET_WIDTH-1:0] GPIO_OUT_OFFSET         = 8'h00;
  localparam logic [OFFSET_WIDTH-1:0] GPIO_OE_OFFSET          = 8'h04;
  localparam logic [OFFSET_WIDTH-1:0] GPIO_IN_OFFSET          = 8'h08;
  localparam logic [OFFSET_WIDTH-1:0] GPIO_INTR_EN_OFFSET     = 8'h0C;
  localparam logic [OFFSET_WIDTH-1:0] GPIO_INTR_STATUS_OFFSET = 8'h10;

endpackage

//--- obi_if.sv
`timescale 1ns/1ns
// ------------------------------
// obi bus interface
// request/grant/rvalid bus between bus and targets
// ------------------------------
interface obi_if;

  // request side
  logic           req;
  logic           gnt;
  obi_pkg::addr_t addr;
  logic           we;
  obi_pkg::be_t   be;
  obi_pkg::data_t wdata;

  // response side
  logic           rvalid;
  obi_pkg::data_t rdata;

  modport manager (
    output req, addr, we, be, wdata,
    input  gnt, rvalid, rdata
  );

  modport subordinate (
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata
  );

endinterface

//--- system_bus.sv
`timescale 1ns/1ns
// ------------------------------
// system bus
// decodes the external manager onto ram, control and gpio
// ------------------------------
module system_bus #(
  parameter int unsigned NUM_BANKS  = mcu_pkg::NUM_BANKS,
  parameter int unsigned BANK_WORDS = mcu_pkg::BANK_WORDS
) (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           ext_req_i,
  input  logic           ext_we_i,
  input  obi_pkg::be_t   ext_be_i,
  input  obi_pkg::addr_t ext_addr_i,
  input  obi_pkg::data_t ext_wdata_i,
  output logic           ext_gnt_o,
  output logic           ext_rvalid_o,
  output obi_pkg::data_t ext_rdata_o,
  obi_if.manager         mem_bus,
  obi_if.manager         ctrl_bus,
  obi_if.manager         gpio_bus
);

  localparam obi_pkg::addr_t RAM_BYTES = obi_pkg::addr_t'(NUM_BANKS * BANK_WORDS * 4);

  typedef enum logic [1:0] {
    SEL_MEM,
    SEL_CTRL,
    SEL_GPIO,
    SEL_NONE
  } sel_e;

  logic ram_hit;
  logic ctrl_hit;
  logic gpio_hit;
  sel_e sel_d;
  sel_e sel_q;
  logic none_rvalid_q;

  // offset compare, so a window at address zero needs no lower bound
  assign ram_hit  = (ext_addr_i - mcu_pkg::RAM_START) < RAM_BYTES;
  assign ctrl_hit = (ext_addr_i - mcu_pkg::SOC_CTRL_START) < mcu_pkg::PERIPH_SIZE;
  assign gpio_hit = (ext_addr_i - mcu_pkg::GPIO_START) < mcu_pkg::PERIPH_SIZE;

  assign mem_bus.req    = ext_req_i & ram_hit;
  assign mem_bus.addr   = ext_addr_i;
  assign mem_bus.we     = ext_we_i;
  assign mem_bus.be     = ext_be_i;
  assign mem_bus.wdata  = ext_wdata_i;

  assign ctrl_bus.req   = ext_req_i & ctrl_hit;
  assign ctrl_bus.addr  = ext_addr_i;
  assign ctrl_bus.we    = ext_we_i;
  assign ctrl_bus.be    = ext_be_i;
  assign ctrl_bus.wdata = ext_wdata_i;

  assign gpio_bus.req   = ext_req_i & gpio_hit;
  assign gpio_bus.addr  = ext_addr_i;
  assign gpio_bus.we    = ext_we_i;
  assign gpio_bus.be    = ext_be_i;
  assign gpio_bus.wdata = ext_wdata_i;

  always_comb begin
    if (ram_hit) begin
      sel_d     = SEL_MEM;
      ext_gnt_o = mem_bus.gnt;
    end else if (ctrl_hit) begin
      sel_d     = SEL_CTRL;
      ext_gnt_o = ctrl_bus.gnt;
    end else if (gpio_hit) begin
      sel_d     = SEL_GPIO;
      ext_gnt_o = gpio_bus.gnt;
    end else begin
      // unmapped, the bus answers itself
      sel_d     = SEL_NONE;
      ext_gnt_o = ext_req_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sel_q         <= SEL_NONE;
      none_rvalid_q <= 1'b0;
    end else begin
      none_rvalid_q <= ext_req_i && ext_gnt_o && (sel_d == SEL_NONE);
      if (ext_req_i && ext_gnt_o) begin
        sel_q <= sel_d;
      end
    end
  end

  // response routing follows the target granted last cycle
  always_comb begin
    case (sel_q)
      SEL_MEM: begin
        ext_rvalid_o = mem_bus.rvalid;
        ext_rdata_o  = mem_bus.rdata;
      end
      SEL_CTRL: begin
        ext_rvalid_o = ctrl_bus.rvalid;
        ext_rdata_o  = ctrl_bus.rdata;
      end
      SEL_GPIO: begin
        ext_rvalid_o = gpio_bus.rvalid;
        ext_rdata_o  = gpio_bus.rdata;
      end
      default: begin
        ext_rvalid_o = none_rvalid_q;
        ext_rdata_o  = '0;
      end
    endcase
  end

  a_single_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({mem_bus.rvalid, ctrl_bus.rvalid, gpio_bus.rvalid, none_rvalid_q}));

endmodule

//--- memory_subsystem.sv
`timescale 1ns/1ns
// ------------------------------
// memory subsystem
// banked word ram with byte enables
// ------------------------------
module memory_subsystem #(
  parameter int unsigned NUM_BANKS  = mcu_pkg::NUM_BANKS,
  parameter int unsigned BANK_WORDS = mcu_pkg::BANK_WORDS
) (
  input logic        clk_i,
  input logic        rst_n_i,
  obi_if.subordinate bus
);

  localparam int unsigned ROW_W  = $clog2(BANK_WORDS);
  localparam int unsigned BANK_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;
  localparam obi_pkg::addr_t RAM_BYTES = obi_pkg::addr_t'(NUM_BANKS * BANK_WORDS * 4);

  obi_pkg::addr_t    word_addr;
  obi_pkg::addr_t    bank_sel;
  logic [ROW_W-1:0]  row;
  logic [BANK_W-1:0] bank_q;
  logic              rvalid_q;
  logic              rd_q;
  obi_pkg::data_t    bank_rdata [NUM_BANKS];

  // banks are contiguous, row bits below bank bits
  assign word_addr = (bus.addr - mcu_pkg::RAM_START) >> 2;
  assign row       = word_addr[ROW_W-1:0];
  assign bank_sel  = word_addr >> ROW_W;

  assign bus.gnt = bus.req;

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
    obi_pkg::data_t words [BANK_WORDS];
    obi_pkg::data_t rdata_q;
    logic           sel;

    assign sel = bus.req && (bank_sel == obi_pkg::addr_t'(b));

    always_ff @(posedge clk_i) begin
      if (sel && bus.we) begin
        for (int i = 0; i < obi_pkg::BE_WIDTH; i++) begin
          if (bus.be[i]) begin
            words[row][8*i +: 8] <= bus.wdata[8*i +: 8];
          end
        end
      end
      if (sel && !bus.we) begin
        rdata_q <= words[row];
      end
    end

    assign bank_rdata[b] = rdata_q;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      rd_q     <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
      rd_q     <= bus.req && !bus.we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      bank_q <= BANK_W'(bank_sel);
    end
  end

  assign bus.rvalid = rvalid_q;
  // writes answer with zero
  assign bus.rdata  = rd_q ? bank_rdata[bank_q] : '0;

  a_addr_in_banks: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus.req |-> (bus.addr - mcu_pkg::RAM_START) < RAM_BYTES);

endmodule

//--- soc_ctrl.sv
`timescale 1ns/1ns
// ------------------------------
// soc control
// always-on exit and scratch registers
// ------------------------------
module soc_ctrl (
  input  logic           clk_i,
  input  logic           rst_n_i,
  obi_if.subordinate     bus,
  output logic           exit_valid_o,
  output obi_pkg::data_t exit_value_o
);

  logic [mcu_pkg::OFFSET_WIDTH-1:0] offset;
  logic                             wr;
  logic                             exit_valid_q;
  obi_pkg::data_t                   exit_value_q;
  obi_pkg::data_t                   scratch_q;
  obi_pkg::data_t                   rdata_d;
  obi_pkg::data_t                   rdata_q;
  logic                             rvalid_q;

  assign offset  = bus.addr[mcu_pkg::OFFSET_WIDTH-1:0];
  // any byte enable writes the whole word
  assign wr      = bus.req && bus.we && (bus.be != '0);
  assign bus.gnt = bus.req;

  always_comb begin
    case (offset)
      mcu_pkg::EXIT_VALID_OFFSET: rdata_d = obi_pkg::data_t'(exit_valid_q);
      mcu_pkg::EXIT_VALUE_OFFSET: rdata_d = exit_value_q;
      mcu_pkg::SCRATCH_OFFSET:    rdata_d = scratch_q;
      default:                    rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
      rvalid_q     <= 1'b0;
      rdata_q      <= '0;
    end else begin
      if (wr && offset == mcu_pkg::EXIT_VALID_OFFSET) begin
        exit_valid_q <= bus.wdata[0];
      end
      if (wr && offset == mcu_pkg::EXIT_VALUE_OFFSET) begin
        exit_value_q <= bus.wdata;
      end
      rvalid_q <= bus.req;
      rdata_q  <= (bus.req && !bus.we) ? rdata_d : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr && offset == mcu_pkg::SCRATCH_OFFSET) begin
      scratch_q <= bus.wdata;
    end
  end

  assign bus.rvalid   = rvalid_q;
  assign bus.rdata    = rdata_q;
  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

//--- gpio.sv
`timescale 1ns/1ns
// ------------------------------
// gpio
// pin registers, input sync and rising-edge interrupts
// ------------------------------
module gpio #(
  parameter int unsigned GPIO_WIDTH = mcu_pkg::GPIO_WIDTH
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  obi_if.subordinate            bus,
  input  logic [GPIO_WIDTH-1:0] gpio_i,
  output logic [GPIO_WIDTH-1:0] gpio_o,
  output logic [GPIO_WIDTH-1:0] gpio_oe_o,
  output logic                  gpio_intr_o
);

  logic [mcu_pkg::OFFSET_WIDTH-1:0] offset;
  logic                             wr;
  logic [GPIO_WIDTH-1:0]            wdata;
  logic [GPIO_WIDTH-1:0]            out_q;
  logic [GPIO_WIDTH-1:0]            oe_q;
  logic [GPIO_WIDTH-1:0]            intr_en_q;
  logic [GPIO_WIDTH-1:0]            status_q;
  logic [GPIO_WIDTH-1:0]            in_meta_q;
  logic [GPIO_WIDTH-1:0]            in_sync_q;
  logic [GPIO_WIDTH-1:0]            in_prev_q;
  logic [GPIO_WIDTH-1:0]            rise;
  logic [GPIO_WIDTH-1:0]            clr;
  obi_pkg::data_t                   rdata_d;
  obi_pkg::data_t                   rdata_q;
  logic                             rvalid_q;

  assign offset  = bus.addr[mcu_pkg::OFFSET_WIDTH-1:0];
  assign wr      = bus.req && bus.we && (bus.be != '0);
  assign wdata   = bus.wdata[GPIO_WIDTH-1:0];
  assign bus.gnt = bus.req;

  assign rise = in_sync_q & ~in_prev_q & intr_en_q;
  // write one to clear but a new edge in the same cycle wins
  assign clr  = (wr && offset == mcu_pkg::GPIO_INTR_STATUS_OFFSET) ? wdata : '0;

  always_comb begin
    case (offset)
      mcu_pkg::GPIO_OUT_OFFSET:         rdata_d = obi_pkg::data_t'(out_q);
      mcu_pkg::GPIO_OE_OFFSET:          rdata_d = obi_pkg::data_t'(oe_q);
      mcu_pkg::GPIO_IN_OFFSET:          rdata_d = obi_pkg::data_t'(in_sync_q);
      mcu_pkg::GPIO_INTR_EN_OFFSET:     rdata_d = obi_pkg::data_t'(intr_en_q);
      mcu_pkg::GPIO_INTR_STATUS_OFFSET: rdata_d = obi_pkg::data_t'(status_q);
      default:                          rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_q     <= '0;
      oe_q      <= '0;
      intr_en_q <= '0;
      status_q  <= '0;
      in_meta_q <= '0;
      in_sync_q <= '0;
      in_prev_q <= '0;
      rvalid_q  <= 1'b0;
      rdata_q   <= '0;
    end else begin
      if (wr && offset == mcu_pkg::GPIO_OUT_OFFSET) begin
        out_q <= wdata;
      end
      if (wr && offset == mcu_pkg::GPIO_OE_OFFSET) begin
        oe_q <= wdata;
      end
      if (wr && offset == mcu_pkg::GPIO_INTR_EN_OFFSET) begin
        intr_en_q <= wdata;
      end
      // two-flop sync plus a third stage for edge detect
      in_meta_q <= gpio_i;
      in_sync_q <= in_meta_q;
      in_prev_q <= in_sync_q;
      status_q  <= (status_q & ~clr) | rise;
      rvalid_q  <= bus.req;
      rdata_q   <= (bus.req && !bus.we) ? rdata_d : '0;
    end
  end

  assign bus.rvalid  = rvalid_q;
  assign bus.rdata   = rdata_q;
  assign gpio_o      = out_q;
  assign gpio_oe_o   = oe_q;
  assign gpio_intr_o = |(status_q & intr_en_q);

endmodule

//--- core_v_mini_mcu.sv
`timescale 1ns/1ns
// ------------------------------
// core-v mini mcu
// external manager, system bus, ram and peripherals
// ------------------------------
module core_v_mini_mcu #(
  parameter int unsigned NUM_BANKS  = mcu_pkg::NUM_BANKS,
  parameter int unsigned BANK_WORDS = mcu_pkg::BANK_WORDS,
  parameter int unsigned GPIO_WIDTH = mcu_pkg::GPIO_WIDTH
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  ext_req_i,
  input  logic                  ext_we_i,
  input  obi_pkg::be_t          ext_be_i,
  input  obi_pkg::addr_t        ext_addr_i,
  input  obi_pkg::data_t        ext_wdata_i,
  output logic                  ext_gnt_o,
  output logic                  ext_rvalid_o,
  output obi_pkg::data_t        ext_rdata_o,
  input  logic [GPIO_WIDTH-1:0] gpio_i,
  output logic [GPIO_WIDTH-1:0] gpio_o,
  output logic [GPIO_WIDTH-1:0] gpio_oe_o,
  output logic                  gpio_intr_o,
  output logic                  exit_valid_o,
  output obi_pkg::data_t        exit_value_o
);

  obi_if mem_bus ();
  obi_if ctrl_bus ();
  obi_if gpio_bus ();

  system_bus #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_WORDS(BANK_WORDS)
  ) system_bus_i (
    .clk_i,
    .rst_n_i,
    .ext_req_i,
    .ext_we_i,
    .ext_be_i,
    .ext_addr_i,
    .ext_wdata_i,
    .ext_gnt_o,
    .ext_rvalid_o,
    .ext_rdata_o,
    .mem_bus (mem_bus.manager),
    .ctrl_bus(ctrl_bus.manager),
    .gpio_bus(gpio_bus.manager)
  );

  memory_subsystem #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_WORDS(BANK_WORDS)
  ) memory_subsystem_i (
    .clk_i,
    .rst_n_i,
    .bus(mem_bus.subordinate)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .rst_n_i,
    .bus(ctrl_bus.subordinate),
    .exit_valid_o,
    .exit_value_o
  );

  gpio #(
    .GPIO_WIDTH(GPIO_WIDTH)
  ) gpio_periph_i (
    .clk_i,
    .rst_n_i,
    .bus(gpio_bus.subordinate),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .gpio_intr_o
  );

endmodule

//--- tb_core_v_mini_mcu.sv
`timescale 1ns/1ns
// ------------------------------
// mini mcu testbench
// bus, exit and gpio checked by assertions
// ------------------------------
module tb_core_v_mini_mcu;

  function automatic obi_pkg::addr_t reg_addr(input obi_pkg::addr_t base,
                                              input logic [mcu_pkg::OFFSET_WIDTH-1:0] off);
    return base | obi_pkg::addr_t'(off);
  endfunction

  localparam int unsigned NUM_BANKS  = mcu_pkg::NUM_BANKS;
  localparam int unsigned BANK_WORDS = mcu_pkg::BANK_WORDS;
  localparam int unsigned GPIO_WIDTH = mcu_pkg::GPIO_WIDTH;
  localparam int CLK_PERIOD = 20;
  localparam int N_WORDS    = 32;
  localparam int N_PARTIAL  = 48;
  localparam int N_UNMAP    = 16;
  localparam int N_MIX      = 40;
  // transfers plus the idle and wait cycles of the peripheral phases
  localparam int TEST_CYCLES = 4 * N_WORDS + N_PARTIAL + 2 * N_UNMAP + N_MIX + 80;
  localparam int WATCHDOG_NS = (TEST_CYCLES + 2) * CLK_PERIOD + 1000;
  localparam int INTR_PIN   = 5;
  localparam int QUIET_PIN  = 9;

  typedef logic [GPIO_WIDTH-1:0] pins_t;

  localparam pins_t INTR_MASK  = pins_t'(1) << INTR_PIN;
  localparam pins_t QUIET_MASK = pins_t'(1) << QUIET_PIN;
  localparam obi_pkg::addr_t RAM_BYTES    = obi_pkg::addr_t'(NUM_BANKS * BANK_WORDS * 4);
  localparam obi_pkg::addr_t EXIT_VALID_A =
    reg_addr(mcu_pkg::SOC_CTRL_START, mcu_pkg::EXIT_VALID_OFFSET);
  localparam obi_pkg::addr_t EXIT_VALUE_A =
    reg_addr(mcu_pkg::SOC_CTRL_START, mcu_pkg::EXIT_VALUE_OFFSET);
  localparam obi_pkg::addr_t SCRATCH_A    =
    reg_addr(mcu_pkg::SOC_CTRL_START, mcu_pkg::SCRATCH_OFFSET);
  localparam obi_pkg::addr_t CTRL_HOLE_A  = reg_addr(mcu_pkg::SOC_CTRL_START, 8'h40);
  localparam obi_pkg::addr_t GPIO_OUT_A   = reg_addr(mcu_pkg::GPIO_START, mcu_pkg::GPIO_OUT_OFFSET);
  localparam obi_pkg::addr_t GPIO_OE_A    = reg_addr(mcu_pkg::GPIO_START, mcu_pkg::GPIO_OE_OFFSET);
  localparam obi_pkg::addr_t GPIO_IN_A    = reg_addr(mcu_pkg::GPIO_START, mcu_pkg::GPIO_IN_OFFSET);
  localparam obi_pkg::addr_t GPIO_EN_A    =
    reg_addr(mcu_pkg::GPIO_START, mcu_pkg::GPIO_INTR_EN_OFFSET);
  localparam obi_pkg::addr_t GPIO_STAT_A  =
    reg_addr(mcu_pkg::GPIO_START, mcu_pkg::GPIO_INTR_STATUS_OFFSET);

  logic           clk_i;
  logic           rst_n_i;
  logic           ext_req_i;
  logic           ext_we_i;
  obi_pkg::be_t   ext_be_i;
  obi_pkg::addr_t ext_addr_i;
  obi_pkg::data_t ext_wdata_i;
  logic           ext_gnt_o;
  logic           ext_rvalid_o;
  obi_pkg::data_t ext_rdata_o;
  pins_t          gpio_i;
  pins_t          gpio_o;
  pins_t          gpio_oe_o;
  logic           gpio_intr_o;
  logic           exit_valid_o;
  obi_pkg::data_t exit_value_o;

  int             seed = 32'h255d77f9;
  int             errors = 0;
  int             n_xfers = 0;
  obi_pkg::data_t exp_rdata = '0;
  obi_pkg::data_t shadow [int unsigned];
  int unsigned    ram_words [N_WORDS];
  obi_pkg::data_t scratch_val;
  pins_t          gpio_out_val;
  logic           edge_armed = 1'b0;
  logic           intr_forbidden = 1'b0;

  // reference model state, updated at the clock edge
  logic           rsp_due_q;
  obi_pkg::data_t rsp_exp_q;
  logic           clr_q;
  int             edge_age;
  pins_t          exp_gpio_out;
  pins_t          exp_gpio_oe;
  logic           exp_exit_valid;
  obi_pkg::data_t exp_exit_value;

  core_v_mini_mcu #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_WORDS(BANK_WORDS),
    .GPIO_WIDTH(GPIO_WIDTH)
  ) dut_i (
    .clk_i,
    .rst_n_i,
    .ext_req_i,
    .ext_we_i,
    .ext_be_i,
    .ext_addr_i,
    .ext_wdata_i,
    .ext_gnt_o,
    .ext_rvalid_o,
    .ext_rdata_o,
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .gpio_intr_o,
    .exit_valid_o,
    .exit_value_o
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Testbench failed");
    $finish;
  end

  function automatic obi_pkg::data_t merge_bytes(input obi_pkg::data_t old_w,
                                                 input obi_pkg::data_t new_w,
                                                 input obi_pkg::be_t be);
    obi_pkg::data_t res;
    res = old_w;
    for (int i = 0; i < obi_pkg::BE_WIDTH; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return res;
  endfunction

  // holes just past each window and far above the map
  function automatic obi_pkg::addr_t unmapped_addr(input int i, input int unsigned w);
    obi_pkg::addr_t off;
    obi_pkg::addr_t res;
    off = obi_pkg::addr_t'(w) << 2;
    case (i % 4)
      0:       res = mcu_pkg::RAM_START + RAM_BYTES + off;
      1:       res = 32'h4000_0000 | off;
      2:       res = mcu_pkg::SOC_CTRL_START + mcu_pkg::PERIPH_SIZE + off;
      default: res = mcu_pkg::GPIO_START + mcu_pkg::PERIPH_SIZE + off;
    endcase
    return res;
  endfunction

  task automatic issue(input logic we, input obi_pkg::be_t be, input obi_pkg::addr_t addr,
                       input obi_pkg::data_t wdata, input obi_pkg::data_t exp);
    #2;
    ext_req_i   = 1'b1;
    ext_we_i    = we;
    ext_be_i    = be;
    ext_addr_i  = addr;
    ext_wdata_i = wdata;
    exp_rdata   = exp;
    n_xfers++;
    @(posedge clk_i);
    while (!ext_gnt_o) begin
      @(posedge clk_i);
    end
  endtask

  task automatic ram_write(input int unsigned w, input obi_pkg::be_t be,
                           input obi_pkg::data_t d);
    obi_pkg::data_t old_w;
    old_w = shadow.exists(w) ? shadow[w] : '0;
    shadow[w] = merge_bytes(old_w, d, be);
    issue(1'b1, be, mcu_pkg::RAM_START + (obi_pkg::addr_t'(w) << 2), d, '0);
  endtask

  task automatic ram_read(input int unsigned w);
    issue(1'b0, 4'hF, mcu_pkg::RAM_START + (obi_pkg::addr_t'(w) << 2), '0, shadow[w]);
  endtask

  // also idles the bus for one cycle
  task automatic set_pins(input pins_t pins, input logic arm, input logic forbid);
    #2;
    ext_req_i      = 1'b0;
    gpio_i         = pins;
    edge_armed     = arm;
    intr_forbidden = forbid;
    @(posedge clk_i);
  endtask

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_due_q      <= 1'b0;
      rsp_exp_q      <= '0;
      clr_q          <= 1'b0;
      edge_age       <= 0;
      exp_gpio_out   <= '0;
      exp_gpio_oe    <= '0;
      exp_exit_valid <= 1'b0;
      exp_exit_value <= '0;
    end else begin
      rsp_due_q <= ext_req_i;
      rsp_exp_q <= exp_rdata;
      clr_q     <= ext_req_i && ext_we_i && ext_addr_i == GPIO_STAT_A && ext_wdata_i[INTR_PIN];
      edge_age  <= edge_armed ? edge_age + 1 : 0;
      if (ext_req_i && ext_we_i && ext_be_i != '0) begin
        case (ext_addr_i)
          GPIO_OUT_A:   exp_gpio_out   <= ext_wdata_i[GPIO_WIDTH-1:0];
          GPIO_OE_A:    exp_gpio_oe    <= ext_wdata_i[GPIO_WIDTH-1:0];
          EXIT_VALID_A: exp_exit_valid <= ext_wdata_i[0];
          EXIT_VALUE_A: exp_exit_value <= ext_wdata_i;
          default: ;
        endcase
      end
    end
  end

  a_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i) !ext_req_i || ext_gnt_o)
    else begin
      errors++;
      $display("[FAIL] %0t request to %h not granted in its cycle", $time, ext_addr_i);
    end

  a_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i) ext_rvalid_o == rsp_due_q)
    else begin
      errors++;
      $display("[FAIL] %0t rvalid %b, expected %b", $time, ext_rvalid_o, rsp_due_q);
    end

  a_rdata: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !rsp_due_q || ext_rdata_o == rsp_exp_q)
    else begin
      errors++;
      $display("[FAIL] %0t rdata %h, expected %h", $time, ext_rdata_o, rsp_exp_q);
    end

  a_pins: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    gpio_o == exp_gpio_out && gpio_oe_o == exp_gpio_oe)
    else begin
      errors++;
      $display("[FAIL] %0t gpio_o %h oe %h, expected %h oe %h", $time, gpio_o, gpio_oe_o,
               exp_gpio_out, exp_gpio_oe);
    end

  a_exit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    exit_valid_o == exp_exit_valid && exit_value_o == exp_exit_value)
    else begin
      errors++;
      $display("[FAIL] %0t exit %b %h, expected %b %h", $time, exit_valid_o, exit_value_o,
               exp_exit_valid, exp_exit_value);
    end

  // line must be up by the fourth edge after the pin change
  a_intr_rise: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(edge_armed && edge_age >= 3) || gpio_intr_o)
    else begin
      errors++;
      $display("[FAIL] %0t gpio_intr_o still low %0d cycles after the edge", $time, edge_age + 1);
    end

  a_intr_clear: assert property (@(posedge clk_i) disable iff (!rst_n_i) !clr_q || !gpio_intr_o)
    else begin
      errors++;
      $display("[FAIL] %0t gpio_intr_o still high after the status clear", $time);
    end

  a_intr_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !intr_forbidden || !gpio_intr_o)
    else begin
      errors++;
      $display("[FAIL] %0t gpio_intr_o raised by a disabled pin", $time);
    end

  initial begin
    obi_pkg::data_t d;
    pins_t          pins;
    int unsigned    w;
    int unsigned    kind;
    int             k;
    rst_n_i     = 1'b0;
    ext_req_i   = 1'b0;
    ext_we_i    = 1'b0;
    ext_be_i    = '0;
    ext_addr_i  = '0;
    ext_wdata_i = '0;
    gpio_i      = '0;
    repeat (2) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    @(posedge clk_i);

    // ram words spread over all banks
    for (int i = 0; i < N_WORDS; i++) begin
      ram_words[i] = (i % NUM_BANKS) * BANK_WORDS + $unsigned($random(seed)) % BANK_WORDS;
      ram_write(ram_words[i], 4'hF, $random(seed));
    end
    for (int i = 0; i < N_PARTIAL; i++) begin
      w = ram_words[$unsigned($random(seed)) % N_WORDS];
      ram_write(w, obi_pkg::be_t'($random(seed)), $random(seed));
    end
    for (int i = 0; i < N_WORDS; i++) begin
      ram_read(ram_words[i]);
    end

    // unmapped traffic must not touch ram
    for (int i = 0; i < N_UNMAP; i++) begin
      issue(1'b1, 4'hF, unmapped_addr(i, ram_words[i]), $random(seed), '0);
    end
    for (int i = 0; i < N_UNMAP; i++) begin
      issue(1'b0, 4'hF, unmapped_addr(i, ram_words[N_WORDS-1-i]), '0, '0);
    end
    for (int i = 0; i < N_WORDS; i++) begin
      ram_read(ram_words[i]);
    end

    // control block
    d = $random(seed) | 32'h1;
    issue(1'b1, 4'hF, EXIT_VALUE_A, d, '0);
    issue(1'b1, 4'hF, EXIT_VALID_A, 32'h1, '0);
    issue(1'b0, 4'hF, EXIT_VALUE_A, '0, d);
    issue(1'b0, 4'hF, EXIT_VALID_A, '0, 32'h1);
    scratch_val = $random(seed);
    issue(1'b1, 4'hF, SCRATCH_A, scratch_val, '0);
    issue(1'b0, 4'hF, SCRATCH_A, '0, scratch_val);
    issue(1'b0, 4'hF, CTRL_HOLE_A, '0, '0);

    // gpio registers and input sync
    gpio_out_val = pins_t'($random(seed));
    pins = pins_t'($random(seed));
    issue(1'b1, 4'hF, GPIO_OUT_A, obi_pkg::data_t'(gpio_out_val), '0);
    issue(1'b1, 4'hF, GPIO_OE_A, obi_pkg::data_t'(pins), '0);
    issue(1'b0, 4'hF, GPIO_OUT_A, '0, obi_pkg::data_t'(gpio_out_val));
    issue(1'b0, 4'hF, GPIO_OE_A, '0, obi_pkg::data_t'(pins));
    pins = pins_t'($random(seed));
    set_pins(pins, 1'b0, 1'b0);
    repeat (2) @(posedge clk_i);
    issue(1'b0, 4'hF, GPIO_IN_A, '0, obi_pkg::data_t'(pins));
    set_pins('0, 1'b0, 1'b0);
    repeat (3) @(posedge clk_i);

    // edge interrupt, clear, then an edge on a disabled pin
    issue(1'b1, 4'hF, GPIO_EN_A, obi_pkg::data_t'(INTR_MASK), '0);
    set_pins(INTR_MASK, 1'b1, 1'b0);
    for (k = 0; k < 8 && !gpio_intr_o; k++) begin
      @(posedge clk_i);
    end
    set_pins(INTR_MASK, 1'b0, 1'b0);
    issue(1'b1, 4'hF, GPIO_STAT_A, obi_pkg::data_t'(INTR_MASK), '0);
    set_pins(INTR_MASK, 1'b0, 1'b1);
    set_pins(INTR_MASK | QUIET_MASK, 1'b0, 1'b1);
    repeat (6) @(posedge clk_i);
    set_pins(INTR_MASK | QUIET_MASK, 1'b0, 1'b0);

    // back-to-back mix of all targets
    for (int i = 0; i < N_MIX; i++) begin
      kind = $unsigned($random(seed)) % 6;
      w    = ram_words[$unsigned($random(seed)) % N_WORDS];
      d    = $random(seed);
      case (kind)
        0: ram_read(w);
        1: ram_write(w, 4'hF, d);
        2: begin
          scratch_val = d;
          issue(1'b1, 4'hF, SCRATCH_A, d, '0);
        end
        3: issue(1'b0, 4'hF, SCRATCH_A, '0, scratch_val);
        4: issue(1'b0, 4'hF, GPIO_OUT_A, '0, obi_pkg::data_t'(gpio_out_val));
        default: issue(1'b0, 4'hF, unmapped_addr(i, w), '0, '0);
      endcase
    end
    set_pins(gpio_i, 1'b0, 1'b0);
    repeat (2) @(posedge clk_i);

    $display("transfers %0d, errors %0d", n_xfers, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- core_v_mini_mcu.f
obi_pkg.sv
mcu_pkg.sv
obi_if.sv
system_bus.sv
memory_subsystem.sv
soc_ctrl.sv
gpio.sv
core_v_mini_mcu.sv
tb_core_v_mini_mcu.sv

//--- Makefile
# Verilator build and run for the mini mcu testbench

VERILATOR ?= verilator
TOP       ?= tb_core_v_mini_mcu
FILELIST  ?= core_v_mini_mcu.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= Testbench passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard *.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
